/* all.f */
+incdir+bench
src/spmmio_pkg.sv
src/spmmio_fifo.sv
src/spmmio_misc.sv
src/spmmio_uart.sv
src/spmmio_keyboard.sv
src/spmmio_sram.sv
src/spmmio.sv
bench/spmmio_tb.sv

/* bench/spmmio_tb_tasks.svh */
localparam int ACK_LIMIT  = 8;    // Cycles without ack before giving up
localparam int POLL_LIMIT = 300;  // Status reads per poll

int    errors       = 0;
int    tests_run    = 0;
int    tests_failed = 0;
int    test_base    = 0;
string test_name;

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
   assert (got === exp)
   else begin
      $display("[FAIL] at %0d ns: %s read %h, expected %h", $time, what, got, exp);
      errors++;
   end
endtask

task automatic start_test(input string name);
   test_name = name;
   test_base = errors;
endtask

task automatic finish_test();
   tests_run++;
   if (errors == test_base) begin
      $display("test %s: passed", test_name);
   end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - test_base);
   end
endtask

// One bus transfer, lat counts the cycles spent waiting for ack
task automatic bus_access(input logic [0:7] unit, input logic [0:3] regno, input logic we,
                          input logic [0:3] sel, input logic [0:31] wdata,
                          output logic [0:31] rdata, output int lat);
   int   waits;
   logic done;
   waits = 0;
   done  = 1'b0;
   rdata = '0;
   @(negedge clk);
   bus_adr         = '0;
   bus_adr[0:7]    = unit;
   bus_adr[18:21]  = regno;
   bus_we          = we;
   bus_sel         = sel;
   bus_dat         = wdata;
   bus_cyc         = 1'b1;
   bus_stb         = 1'b1;
   while (!done && waits < ACK_LIMIT) begin
      #1;
      if (ack) begin
         done  = 1'b1;
         rdata = rdat;
      end else begin
         @(negedge clk);
         waits++;
      end
   end
   if (done) begin
      @(negedge clk);  // Past the acknowledging edge
   end else begin
      $display("Bus access to unit %h register %0d got no acknowledge in time", unit, regno);
      errors++;
   end
   bus_cyc = 1'b0;
   bus_stb = 1'b0;
   bus_we  = 1'b0;
   lat     = waits;
endtask

task automatic bus_write(input logic [0:7] unit, input logic [0:3] regno,
                         input logic [0:3] sel, input logic [0:31] wdata);
   logic [0:31] unused;
   int          lat;
   bus_access(unit, regno, 1'b1, sel, wdata, unused, lat);
endtask

task automatic bus_read(input logic [0:7] unit, input logic [0:3] regno,
                        output logic [0:31] rdata);
   int lat;
   bus_access(unit, regno, 1'b0, 4'hF, '0, rdata, lat);
endtask

// Reads UART status until one bit reaches the wanted level
task automatic poll_uart(input int bit_idx, input logic want, input string what);
   logic [0:31] stat;
   int          n;
   n = 0;
   bus_read(spmmio_pkg::UNIT_UART, spmmio_pkg::UART_STAT, stat);
   while (stat[bit_idx] !== want && n < POLL_LIMIT) begin
      bus_read(spmmio_pkg::UNIT_UART, spmmio_pkg::UART_STAT, stat);
      n++;
   end
   if (stat[bit_idx] !== want) begin
      $display("Waiting for UART %s timed out", what);
      errors++;
   end
endtask

/* bench/spmmio_tb.sv */
`timescale 1ns/1ps

module spmmio_tb;

   logic        clk;
   logic        rst_n;
   logic [0:23] bus_adr;
   logic        bus_cyc;
   logic        bus_stb;
   logic        bus_we;
   logic [0:3]  bus_sel;
   logic [0:31] bus_dat;
   logic        ack;
   logic [0:31] rdat;
   logic        led_red;
   logic        led_green;
   logic [0:4]  sw_reset;
   logic [0:3]  sw_enable;
   logic [0:23] led1_rgb;
   logic [1:3]  drive_activity;
   logic        txd;
   logic        keypress;
   logic        keypress_isup;
   logic [0:6]  keycode;
   logic [0:3]  shift_state;
   logic        kbd_block;
   logic [0:31] misc_exp [3];
   logic [0:31] sram_exp [spmmio_pkg::SRAM_WORDS];

   `include "spmmio_tb_tasks.svh"

   spmmio UUT (
      .clk(clk), .rst_n_i(rst_n),
      .adr_i(bus_adr), .cyc_i(bus_cyc), .stb_i(bus_stb), .we_i(bus_we),
      .sel_i(bus_sel), .dat_i(bus_dat), .ack_o(ack), .dat_o(rdat),
      .led_red_o(led_red), .led_green_o(led_green), .sw_reset_o(sw_reset),
      .sw_enable_o(sw_enable), .led1_rgb_o(led1_rgb), .drive_activity_i(drive_activity),
      .uart_txd_o(txd), .uart_rxd_i(txd),  // Loopback
      .keypress_i(keypress), .keypress_isup_i(keypress_isup), .keycode_i(keycode),
      .shift_state_i(shift_state), .keyboard_block_o(kbd_block));

   always #2 clk = ~clk;

   // Bits each misc register really holds
   function automatic logic [0:31] field_mask(input logic [0:3] r);
      case (r)
         4'd0:    return 32'h0000_0003;
         4'd1:    return 32'h0000_1F0F;
         default: return 32'h00FF_FFFF;
      endcase
   endfunction

   function automatic logic [0:31] event_word(input spmmio_pkg::kbd_event_t ev);
      logic [0:31] w;
      w        = '0;
      w[19]    = ev.isup;
      w[20:23] = ev.shift_state;
      w[24:30] = ev.keycode;
      w[31]    = 1'b1;  // Valid
      return w;
   endfunction

   task automatic check_misc_outputs();
      check_value("LED outputs", {30'b0, led_red, led_green}, misc_exp[0]);
      check_value("switch outputs", {19'b0, sw_reset, 4'b0, sw_enable}, misc_exp[1]);
      check_value("RGB output", {8'b0, led1_rgb}, misc_exp[2]);
   endtask

   task automatic pulse_key(input spmmio_pkg::kbd_event_t ev);
      @(negedge clk);
      keypress      = 1'b1;
      keypress_isup = ev.isup;
      shift_state   = ev.shift_state;
      keycode       = ev.keycode;
      @(negedge clk);
      keypress = 1'b0;
   endtask

   task automatic send_byte(input logic [7:0] b);
      poll_uart(0, 1'b0, "transmitter idle");
      bus_write(spmmio_pkg::UNIT_UART, spmmio_pkg::UART_DATA, 4'hF, {24'b0, b});
   endtask

   task automatic test_misc();
      logic [0:31] wdata;
      logic [0:31] rd;
      logic [0:31] bmask;
      logic [0:3]  sel;
      logic [0:3]  r;
      start_test("misc registers");
      for (int i = 0; i < 24; i++) begin
         r     = 4'($urandom_range(2));
         wdata = $urandom;
         sel   = 4'($urandom);
         bmask = '0;
         for (int b = 0; b < 4; b++) begin
            if (sel[b])
               bmask = bmask | (32'hFF00_0000 >> (8 * b));
         end
         misc_exp[r] = ((misc_exp[r] & ~bmask) | (wdata & bmask)) & field_mask(r);
         bus_write(spmmio_pkg::UNIT_MISC, r, sel, wdata);
         bus_read(spmmio_pkg::UNIT_MISC, r, rd);
         check_value("misc readback", rd, misc_exp[r]);
         check_misc_outputs();
      end
      for (int i = 0; i < 4; i++) begin
         drive_activity = 3'($urandom);
         bus_read(spmmio_pkg::UNIT_MISC, spmmio_pkg::MISC_ACT, rd);
         check_value("drive activity", rd, {29'b0, drive_activity});
      end
      finish_test();
   endtask

   task automatic test_sram();
      logic [0:31] rd;
      int          lat;
      start_test("scratch RAM");
      for (int i = 0; i < spmmio_pkg::SRAM_WORDS; i++) begin
         sram_exp[i] = $urandom;
         bus_access(spmmio_pkg::UNIT_SRAM, 4'(i), 1'b1, 4'hF, sram_exp[i], rd, lat);
         check_value("SRAM write wait states", lat, 1);
      end
      for (int i = 0; i < spmmio_pkg::SRAM_WORDS; i++) begin
         bus_access(spmmio_pkg::UNIT_SRAM, 4'(i), 1'b0, 4'hF, '0, rd, lat);
         check_value("SRAM read wait states", lat, 1);
         check_value("SRAM word", rd, sram_exp[i]);
      end
      finish_test();
   endtask

   task automatic test_uart();
      logic [7:0]  sent [$];
      logic [7:0]  b;
      logic [0:31] rd;
      start_test("UART loopback");
      for (int i = 0; i < 4; i++) begin
         b = 8'($urandom);
         send_byte(b);
         poll_uart(1, 1'b1, "receive data");
         bus_read(spmmio_pkg::UNIT_UART, spmmio_pkg::UART_DATA, rd);
         check_value("UART received byte", rd, {24'b0, b});
      end
      // One byte more than the FIFO holds
      for (int i = 0; i <= spmmio_pkg::FIFO_DEPTH; i++) begin
         b = 8'($urandom);
         sent.push_back(b);
         send_byte(b);
      end
      poll_uart(2, 1'b1, "overrun flag");
      bus_read(spmmio_pkg::UNIT_UART, spmmio_pkg::UART_STAT, rd);
      check_value("UART overrun after status read", rd[2], 0);
      for (int i = 0; i < spmmio_pkg::FIFO_DEPTH; i++) begin
         bus_read(spmmio_pkg::UNIT_UART, spmmio_pkg::UART_DATA, rd);
         check_value("UART queued byte", rd, {24'b0, sent[i]});
      end
      bus_read(spmmio_pkg::UNIT_UART, spmmio_pkg::UART_STAT, rd);
      check_value("UART rx valid when drained", rd[1], 0);
      finish_test();
   endtask

   task automatic test_keyboard();
      spmmio_pkg::kbd_event_t ev;
      spmmio_pkg::kbd_event_t sent [$];
      logic [31:0]            raw;
      logic [0:31]            rd;
      start_test("keyboard queue");
      for (int i = 0; i < 3; i++) begin
         raw = $urandom;
         ev  = raw[11:0];
         sent.push_back(ev);
         pulse_key(ev);
      end
      for (int i = 0; i < 3; i++) begin
         bus_read(spmmio_pkg::UNIT_KBD, spmmio_pkg::KBD_EVENT, rd);
         check_value("key event", rd, event_word(sent[i]));
      end
      bus_read(spmmio_pkg::UNIT_KBD, spmmio_pkg::KBD_EVENT, rd);
      check_value("empty key queue", rd, 0);
      sent.delete();
      for (int i = 0; i <= spmmio_pkg::FIFO_DEPTH; i++) begin
         raw = $urandom;
         ev  = raw[11:0];
         sent.push_back(ev);
         pulse_key(ev);
      end
      bus_read(spmmio_pkg::UNIT_KBD, spmmio_pkg::KBD_STAT, rd);
      check_value("keyboard overrun set", rd, 32'h8000_0000);
      bus_read(spmmio_pkg::UNIT_KBD, spmmio_pkg::KBD_STAT, rd);
      check_value("keyboard overrun cleared", rd, 0);
      for (int i = 0; i < spmmio_pkg::FIFO_DEPTH; i++) begin
         bus_read(spmmio_pkg::UNIT_KBD, spmmio_pkg::KBD_EVENT, rd);
         check_value("queued key event", rd, event_word(sent[i]));
      end
      bus_read(spmmio_pkg::UNIT_KBD, spmmio_pkg::KBD_EVENT, rd);
      check_value("drained key queue", rd, 0);
      bus_write(spmmio_pkg::UNIT_KBD, spmmio_pkg::KBD_CTRL, 4'b1000, 32'h8000_0000);
      check_value("keyboard block on", kbd_block, 1);
      bus_read(spmmio_pkg::UNIT_KBD, spmmio_pkg::KBD_CTRL, rd);
      check_value("keyboard control", rd, 32'h8000_0000);
      bus_write(spmmio_pkg::UNIT_KBD, spmmio_pkg::KBD_CTRL, 4'b1000, 32'h0);
      check_value("keyboard block off", kbd_block, 0);
      finish_test();
   endtask

   task automatic test_unmapped();
      logic [0:7]  unit;
      logic [0:3]  r;
      logic [0:31] rd;
      int          lat;
      start_test("unmapped unit");
      for (int i = 0; i < 6; i++) begin
         unit = 8'($urandom_range(255, 4));
         r    = 4'($urandom);
         bus_access(unit, r, 1'b1, 4'hF, $urandom, rd, lat);
         check_value("unmapped write latency", lat, 0);
         bus_access(unit, r, 1'b0, 4'hF, '0, rd, lat);
         check_value("unmapped read latency", lat, 0);
         check_value("unmapped read data", rd, 0);
         check_misc_outputs();
         bus_read(spmmio_pkg::UNIT_SRAM, r, rd);
         check_value("SRAM after unmapped write", rd, sram_exp[r]);
         bus_read(spmmio_pkg::UNIT_UART, spmmio_pkg::UART_STAT, rd);
         check_value("UART status after unmapped write", rd, 0);
         check_value("keyboard block after unmapped write", kbd_block, 0);
      end
      finish_test();
   endtask

   initial begin
      void'($urandom(57));
      clk            = 1'b0;
      rst_n          = 1'b0;
      bus_adr        = '0;
      bus_cyc        = 1'b0;
      bus_stb        = 1'b0;
      bus_we         = 1'b0;
      bus_sel        = '0;
      bus_dat        = '0;
      drive_activity = '0;
      keypress       = 1'b0;
      keypress_isup  = 1'b0;
      keycode        = '0;
      shift_state    = '0;
      for (int i = 0; i < 3; i++)
         misc_exp[i] = '0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;

      start_test("reset state");
      check_value("ack with strobe low", ack, 0);
      check_misc_outputs();
      check_value("UART line idle", txd, 1);
      check_value("keyboard block", kbd_block, 0);
      finish_test();

      test_misc();
      test_sram();
      test_uart();
      test_keyboard();
      test_unmapped();

      $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

/* src/spmmio.sv */
`timescale 1ns/1ps

module spmmio (
   input  logic        clk,
   input  logic        rst_n_i,

   input  logic [0:23] adr_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [0:3]  sel_i,
   input  logic [0:31] dat_i,
   output logic        ack_o,
   output logic [0:31] dat_o,

   output logic        led_red_o,
   output logic        led_green_o,
   output logic [0:4]  sw_reset_o,
   output logic [0:3]  sw_enable_o,
   output logic [0:23] led1_rgb_o,
   input  logic [1:3]  drive_activity_i,

   output logic        uart_txd_o,
   input  logic        uart_rxd_i,

   input  logic        keypress_i,
   input  logic        keypress_isup_i,
   input  logic [0:6]  keycode_i,
   input  logic [0:3]  shift_state_i,
   output logic        keyboard_block_o
);

   spmmio_pkg::mmio_req_t bus_req;
   spmmio_pkg::mmio_req_t misc_req;
   spmmio_pkg::mmio_req_t uart_req;
   spmmio_pkg::mmio_req_t sram_req;
   spmmio_pkg::mmio_req_t kbd_req;
   spmmio_pkg::mmio_rsp_t misc_rsp;
   spmmio_pkg::mmio_rsp_t uart_rsp;
   spmmio_pkg::mmio_rsp_t sram_rsp;
   spmmio_pkg::mmio_rsp_t kbd_rsp;

   assign bus_req = '{adr: adr_i, cyc: cyc_i, stb: stb_i, we: we_i, sel: sel_i, dat: dat_i};

   always_comb begin
      misc_req     = bus_req;
      uart_req     = bus_req;
      sram_req     = bus_req;
      kbd_req      = bus_req;
      misc_req.stb = 1'b0;
      uart_req.stb = 1'b0;
      sram_req.stb = 1'b0;
      kbd_req.stb  = 1'b0;
      ack_o        = cyc_i && stb_i;  // Unmapped units ack at once
      dat_o        = '0;

      case (adr_i[0:7])
         spmmio_pkg::UNIT_MISC: begin
            misc_req.stb = stb_i;
            ack_o        = misc_rsp.ack;
            dat_o        = misc_rsp.dat;
         end
         spmmio_pkg::UNIT_UART: begin
            uart_req.stb = stb_i;
            ack_o        = uart_rsp.ack;
            dat_o        = uart_rsp.dat;
         end
         spmmio_pkg::UNIT_SRAM: begin
            sram_req.stb = stb_i;
            ack_o        = sram_rsp.ack;  // One wait state
            dat_o        = sram_rsp.dat;
         end
         spmmio_pkg::UNIT_KBD: begin
            kbd_req.stb = stb_i;
            ack_o       = kbd_rsp.ack;
            dat_o       = kbd_rsp.dat;
         end
         default: ;
      endcase
   end

   spmmio_misc misc (
      .clk(clk), .rst_n_i(rst_n_i), .req_i(misc_req), .rsp_o(misc_rsp),
      .led_red_o(led_red_o), .led_green_o(led_green_o),
      .sw_reset_o(sw_reset_o), .sw_enable_o(sw_enable_o),
      .led1_rgb_o(led1_rgb_o), .drive_activity_i(drive_activity_i));

   spmmio_uart uart (
      .clk(clk), .rst_n_i(rst_n_i), .req_i(uart_req), .rsp_o(uart_rsp),
      .uart_txd_o(uart_txd_o), .uart_rxd_i(uart_rxd_i));

   spmmio_sram sram (
      .clk(clk), .rst_n_i(rst_n_i), .req_i(sram_req), .rsp_o(sram_rsp));

   spmmio_keyboard keyboard (
      .clk(clk), .rst_n_i(rst_n_i), .req_i(kbd_req), .rsp_o(kbd_rsp),
      .keypress_i(keypress_i), .keypress_isup_i(keypress_isup_i),
      .keycode_i(keycode_i), .shift_state_i(shift_state_i),
      .keyboard_block_o(keyboard_block_o));

endmodule

/* src/spmmio_fifo.sv */
`timescale 1ns/1ps

module spmmio_fifo #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk,
   input  logic     rst_n_i,
   input  logic     push_i,
   input  payload_t data_i,
   input  logic     pop_i,
   output payload_t data_o,
   output logic     empty_o,
   output logic     full_o
);

   payload_t                          mem [spmmio_pkg::FIFO_DEPTH];
   logic [spmmio_pkg::FIFO_AW-1:0]    wr_ptr;
   logic [spmmio_pkg::FIFO_AW-1:0]    rd_ptr;
   logic [spmmio_pkg::FIFO_AW:0]      count;
   logic                              do_push;
   logic                              do_pop;

   assign do_push = push_i && !full_o;  // Full drops the push
   assign do_pop  = pop_i && !empty_o;

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   // Fall-through head
   assign data_o  = mem[rd_ptr];
   assign empty_o = (count == '0);
   assign full_o  = (count == (spmmio_pkg::FIFO_AW + 1)'(spmmio_pkg::FIFO_DEPTH));

endmodule

/* src/spmmio_keyboard.sv */
`timescale 1ns/1ps

module spmmio_keyboard (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  spmmio_pkg::mmio_req_t req_i,
   output spmmio_pkg::mmio_rsp_t rsp_o,
   input  logic                  keypress_i,
   input  logic                  keypress_isup_i,
   input  logic [0:6]            keycode_i,
   input  logic [0:3]            shift_state_i,
   output logic                  keyboard_block_o
);

   logic [0:spmmio_pkg::REG_W-1] regno;
   logic                         rd;
   logic                         wr;
   logic                         kp_q;
   spmmio_pkg::kbd_event_t       ev_q;
   spmmio_pkg::kbd_event_t       ev_head;
   logic                         ev_empty;
   logic                         ev_full;
   logic                         overrun;

   assign regno = req_i.adr[spmmio_pkg::REG_LSB -: spmmio_pkg::REG_W];
   assign rd    = req_i.cyc && req_i.stb && !req_i.we;
   assign wr    = req_i.cyc && req_i.stb && req_i.we;

   always_ff @(posedge clk) begin
      if (!rst_n_i)
         kp_q <= 1'b0;
      else
         kp_q <= keypress_i;
   end

   always_ff @(posedge clk) begin
      ev_q <= '{isup: keypress_isup_i, shift_state: shift_state_i, keycode: keycode_i};
   end

   // Queued even while blocked
   spmmio_fifo #(.payload_t(spmmio_pkg::kbd_event_t)) event_fifo (
      .clk(clk), .rst_n_i(rst_n_i),
      .push_i(kp_q), .data_i(ev_q),
      .pop_i(rd && regno == spmmio_pkg::KBD_EVENT), .data_o(ev_head),
      .empty_o(ev_empty), .full_o(ev_full));

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         keyboard_block_o <= 1'b0;
         overrun          <= 1'b0;
      end else begin
         if (wr && regno == spmmio_pkg::KBD_CTRL && req_i.sel[0])
            keyboard_block_o <= req_i.dat[0];
         if (kp_q && ev_full)
            overrun <= 1'b1;
         else if (rd && regno == spmmio_pkg::KBD_STAT)
            overrun <= 1'b0;
      end
   end

   always_comb begin
      rsp_o.ack = req_i.cyc && req_i.stb;
      rsp_o.dat = '0;
      case (regno)
         spmmio_pkg::KBD_EVENT: if (!ev_empty) rsp_o.dat[19:31] = {ev_head, 1'b1};  // Valid at 31
         spmmio_pkg::KBD_CTRL:  rsp_o.dat[0] = keyboard_block_o;
         spmmio_pkg::KBD_STAT:  rsp_o.dat[0] = overrun;
         default: ;
      endcase
   end

endmodule

/* src/spmmio_misc.sv */
`timescale 1ns/1ps

module spmmio_misc (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  spmmio_pkg::mmio_req_t req_i,
   output spmmio_pkg::mmio_rsp_t rsp_o,
   output logic                  led_red_o,
   output logic                  led_green_o,
   output logic [0:4]            sw_reset_o,
   output logic [0:3]            sw_enable_o,
   output logic [0:23]           led1_rgb_o,
   input  logic [1:3]            drive_activity_i
);

   logic [0:spmmio_pkg::REG_W-1] regno;
   logic                         wr;
   logic [0:31]                  rd_img;
   logic [0:31]                  wr_img;

   // Byte lane 0 is dat[0:7]
   function automatic logic [0:31] merge(input logic [0:31] old_v, input logic [0:31] new_v,
                                         input logic [0:3] sel);
      logic [0:31] res;
      res = old_v;
      for (int b = 0; b < 4; b++) begin
         if (sel[b])
            res[b*8 +: 8] = new_v[b*8 +: 8];
      end
      return res;
   endfunction

   assign regno = req_i.adr[spmmio_pkg::REG_LSB -: spmmio_pkg::REG_W];
   assign wr    = req_i.cyc && req_i.stb && req_i.we;

   always_comb begin
      case (regno)
         spmmio_pkg::MISC_LED: rd_img = {30'b0, led_red_o, led_green_o};
         spmmio_pkg::MISC_SW:  rd_img = {19'b0, sw_reset_o, 4'b0, sw_enable_o};
         spmmio_pkg::MISC_RGB: rd_img = {8'b0, led1_rgb_o};
         spmmio_pkg::MISC_ACT: rd_img = {29'b0, drive_activity_i};  // Read only
         default:              rd_img = '0;
      endcase
   end

   assign wr_img    = merge(rd_img, req_i.dat, req_i.sel);
   assign rsp_o.ack = req_i.cyc && req_i.stb;
   assign rsp_o.dat = rd_img;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         led_red_o   <= 1'b0;
         led_green_o <= 1'b0;
         sw_reset_o  <= '0;
         sw_enable_o <= '0;
         led1_rgb_o  <= '0;
      end else if (wr) begin
         case (regno)
            spmmio_pkg::MISC_LED: {led_red_o, led_green_o} <= wr_img[30:31];
            spmmio_pkg::MISC_SW: begin
               sw_reset_o  <= wr_img[19:23];
               sw_enable_o <= wr_img[28:31];
            end
            spmmio_pkg::MISC_RGB: led1_rgb_o <= wr_img[8:31];
            default: ;
         endcase
      end
   end

endmodule

/* src/spmmio_pkg.sv */
package spmmio_pkg;

   typedef struct packed {
      logic [0:23] adr;  // Word address, bit 21 is the last significant one
      logic        cyc;
      logic        stb;
      logic        we;
      logic [0:3]  sel;
      logic [0:31] dat;
   } mmio_req_t;

   typedef struct packed {
      logic        ack;
      logic [0:31] dat;
   } mmio_rsp_t;

   // Unit byte, adr[0:7]
   localparam logic [0:7] UNIT_MISC = 8'h00;
   localparam logic [0:7] UNIT_UART = 8'h01;
   localparam logic [0:7] UNIT_SRAM = 8'h02;
   localparam logic [0:7] UNIT_KBD  = 8'h03;

   localparam int REG_LSB = 21;
   localparam int REG_W   = 4;

   localparam logic [0:REG_W-1] MISC_LED  = 4'd0;
   localparam logic [0:REG_W-1] MISC_SW   = 4'd1;
   localparam logic [0:REG_W-1] MISC_RGB  = 4'd2;
   localparam logic [0:REG_W-1] MISC_ACT  = 4'd3;
   localparam logic [0:REG_W-1] UART_DATA = 4'd0;
   localparam logic [0:REG_W-1] UART_STAT = 4'd1;
   localparam logic [0:REG_W-1] KBD_EVENT = 4'd0;
   localparam logic [0:REG_W-1] KBD_CTRL  = 4'd1;
   localparam logic [0:REG_W-1] KBD_STAT  = 4'd2;

   localparam int UART_DIV   = 8;  // Clocks per bit
   localparam int UART_DIV_W = $clog2(UART_DIV);
   localparam logic [UART_DIV_W-1:0] UART_DIV_HALF = UART_DIV_W'(UART_DIV / 2);
   localparam logic [UART_DIV_W-1:0] UART_DIV_LAST = UART_DIV_W'(UART_DIV - 1);

   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
   localparam int SRAM_WORDS = 16;

   typedef struct packed {
      logic       isup;
      logic [0:3] shift_state;
      logic [0:6] keycode;
   } kbd_event_t;

endpackage

/* src/spmmio_sram.sv */
`timescale 1ns/1ps

module spmmio_sram (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  spmmio_pkg::mmio_req_t req_i,
   output spmmio_pkg::mmio_rsp_t rsp_o
);

   logic [0:31]                  mem [spmmio_pkg::SRAM_WORDS];
   logic [0:spmmio_pkg::REG_W-1] idx;
   logic                         req_act;
   logic                         ack_q;
   logic [0:31]                  rd_q;

   assign idx     = req_i.adr[spmmio_pkg::REG_LSB -: spmmio_pkg::REG_W];
   assign req_act = req_i.cyc && req_i.stb;

   // First edge captures data, second edge acks
   always_ff @(posedge clk) begin
      if (!rst_n_i)
         ack_q <= 1'b0;
      else
         ack_q <= req_act && !ack_q;
   end

   always_ff @(posedge clk) begin
      if (req_act && !ack_q)
         rd_q <= mem[idx];
   end

   // Write lands on the acknowledging edge
   always_ff @(posedge clk) begin
      if (req_act && ack_q && req_i.we) begin
         for (int b = 0; b < 4; b++) begin
            if (req_i.sel[b])
               mem[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
         end
      end
   end

   assign rsp_o.ack = ack_q && req_act;
   assign rsp_o.dat = rd_q;

endmodule

/* src/spmmio_uart.sv */
`timescale 1ns/1ps

module spmmio_uart (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  spmmio_pkg::mmio_req_t req_i,
   output spmmio_pkg::mmio_rsp_t rsp_o,
   output logic                  uart_txd_o,
   input  logic                  uart_rxd_i
);

   logic [0:spmmio_pkg::REG_W-1]        regno;
   logic                                rd;
   logic                                tx_start;
   logic                                tx_busy;
   logic [spmmio_pkg::UART_DIV_W-1:0]   tx_div;
   logic [3:0]                          tx_bits;
   logic [9:0]                          tx_shift;
   logic [1:0]                          rxd_sync;
   logic                                rx_busy;
   logic [spmmio_pkg::UART_DIV_W-1:0]   rx_div;
   logic [3:0]                          rx_bits;
   logic [7:0]                          rx_shift;
   logic                                rx_push;
   logic [7:0]                          rx_byte;
   logic                                rx_empty;
   logic                                rx_full;
   logic                                overrun;

   assign regno    = req_i.adr[spmmio_pkg::REG_LSB -: spmmio_pkg::REG_W];
   assign rd       = req_i.cyc && req_i.stb && !req_i.we;
   assign tx_start = req_i.cyc && req_i.stb && req_i.we && regno == spmmio_pkg::UART_DATA
                     && !tx_busy;  // Busy writes are dropped
   assign uart_txd_o = tx_shift[0];

   // Stop, data LSB first, start
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         tx_busy  <= 1'b0;
         tx_div   <= '0;
         tx_bits  <= '0;
         tx_shift <= '1;
      end else if (tx_busy) begin
         if (tx_div == spmmio_pkg::UART_DIV_LAST) begin
            tx_div   <= '0;
            tx_shift <= {1'b1, tx_shift[9:1]};
            if (tx_bits == 4'd9)
               tx_busy <= 1'b0;
            else
               tx_bits <= tx_bits + 4'd1;
         end else begin
            tx_div <= tx_div + 1'b1;
         end
      end else if (tx_start) begin
         tx_busy  <= 1'b1;
         tx_div   <= '0;
         tx_bits  <= '0;
         tx_shift <= {1'b1, req_i.dat[24:31], 1'b0};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         rxd_sync <= 2'b11;
         rx_busy  <= 1'b0;
         rx_div   <= '0;
         rx_bits  <= '0;
         rx_push  <= 1'b0;
      end else begin
         rxd_sync <= {rxd_sync[0], uart_rxd_i};
         rx_push  <= 1'b0;
         if (!rx_busy) begin
            if (!rxd_sync[1]) begin
               rx_busy <= 1'b1;
               rx_div  <= spmmio_pkg::UART_DIV_HALF;  // Aim at mid-bit
               rx_bits <= '0;
            end
         end else if (rx_div == spmmio_pkg::UART_DIV_LAST) begin
            rx_div <= '0;
            if (rx_bits == 4'd0 && rxd_sync[1]) begin
               rx_busy <= 1'b0;  // Glitch, not a start bit
            end else if (rx_bits == 4'd9) begin
               rx_busy <= 1'b0;
               rx_push <= rxd_sync[1];  // Framing error drops the byte
            end else begin
               if (rx_bits != 4'd0)
                  rx_shift <= {rxd_sync[1], rx_shift[7:1]};
               rx_bits <= rx_bits + 4'd1;
            end
         end else begin
            rx_div <= rx_div + 1'b1;
         end
      end
   end

   spmmio_fifo #(.payload_t(logic [7:0])) rx_fifo (
      .clk(clk), .rst_n_i(rst_n_i),
      .push_i(rx_push), .data_i(rx_shift),
      .pop_i(rd && regno == spmmio_pkg::UART_DATA), .data_o(rx_byte),
      .empty_o(rx_empty), .full_o(rx_full));

   always_ff @(posedge clk) begin
      if (!rst_n_i)
         overrun <= 1'b0;
      else if (rx_push && rx_full)
         overrun <= 1'b1;
      else if (rd && regno == spmmio_pkg::UART_STAT)
         overrun <= 1'b0;
   end

   always_comb begin
      rsp_o.ack = req_i.cyc && req_i.stb;
      rsp_o.dat = '0;
      case (regno)
         spmmio_pkg::UART_DATA: if (!rx_empty) rsp_o.dat[24:31] = rx_byte;
         spmmio_pkg::UART_STAT: rsp_o.dat[0:2] = {tx_busy, !rx_empty, overrun};
         default: ;
      endcase
   end

endmodule
